/* Bender.yml */
package:
  name: ntm_matrix_product

sources:
  - include_dirs:
      - hw
    files:
      - hw/ntm_pkg.sv
      - hw/ntm_scalar_if.sv
      - hw/ntm_scalar_adder.sv
      - hw/ntm_scalar_multiplier.sv
      - hw/ntm_matrix_buffer.sv
      - hw/ntm_matrix_product.sv
  - target: test
    include_dirs:
      - hw
      - testbench
    files:
      - testbench/ntm_matrix_product_tb.sv

/* build.f */
+incdir+hw
+incdir+testbench
hw/ntm_pkg.sv
hw/ntm_scalar_if.sv
hw/ntm_scalar_adder.sv
hw/ntm_scalar_multiplier.sv
hw/ntm_matrix_buffer.sv
hw/ntm_matrix_product.sv
testbench/ntm_matrix_product_tb.sv

/* hw/ntm_defines.svh */
/*
  Global widths and limits for the matrix product block
  Element and modulo width, largest dimension, index width
*/

`ifndef NTM_DEFINES_SVH
`define NTM_DEFINES_SVH

// Width of one matrix element and of the modulo
`define NTM_DATA_SIZE 16

// Largest row or column count of any matrix
`define NTM_MAX_DIM 4

// Wide enough to hold NTM_MAX_DIM itself
`define NTM_INDEX_SIZE 3

`endif

/* hw/ntm_matrix_buffer.sv */
/*
  Element store for one operand matrix
  Row/column write pointers driven by I and J strobes
  Combinational read by row and column
*/

`timescale 1ns/10ps

`include "ntm_defines.svh"

module ntm_matrix_buffer (
  input logic CLK,
  input logic RST,
  input logic clear,
  input logic i_enable,
  input logic j_enable,
  input ntm_pkg::data_t data_in,
  input ntm_pkg::index_t rd_row,
  input ntm_pkg::index_t rd_col,
  output ntm_pkg::data_t rd_data
);

  localparam int ADDR_W = $clog2(`NTM_MAX_DIM);

  // Element storage
  ntm_pkg::data_t mem [`NTM_MAX_DIM][`NTM_MAX_DIM];

  // Write pointers
  ntm_pkg::index_t row_ptr;
  ntm_pkg::index_t col_ptr;
  // Set once the first row has been opened
  logic row_open;

  // Target of the current strobe
  ntm_pkg::index_t wr_row;
  ntm_pkg::index_t wr_col;

  ////////////////////////////////////////
  // Write address
  ////////////////////////////////////////

  always_comb begin
    if (i_enable) begin
      // New row, first one after clear is row 0
      wr_row = row_open ? row_ptr + 1'b1 : '0;
      wr_col = '0;
    end else begin
      wr_row = row_ptr;
      wr_col = col_ptr;
    end
  end

  // Pointers
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      row_ptr <= '0;
      col_ptr <= '0;
      row_open <= 1'b0;
    end else if (clear) begin
      row_ptr <= '0;
      col_ptr <= '0;
      row_open <= 1'b0;
    end else if (j_enable) begin
      row_ptr <= wr_row;
      col_ptr <= wr_col + 1'b1;
      row_open <= 1'b1;
    end
  end

  // Storage write on the strobe edge
  always_ff @(posedge CLK) begin
    if (j_enable && !clear) begin
      mem[wr_row[ADDR_W-1:0]][wr_col[ADDR_W-1:0]] <= data_in;
    end
  end

  // Read port
  assign rd_data = mem[rd_row[ADDR_W-1:0]][rd_col[ADDR_W-1:0]];

endmodule

/* hw/ntm_matrix_product.sv */
/*
  Modular matrix product C = A*B mod MODULO_IN
  Operand buffers, scalar multiplier and adder, control FSM
  C streams out row-major with row and element strobes
*/

`timescale 1ns/10ps

module ntm_matrix_product (
  input logic CLK,
  input logic RST,
  input logic START,
  input logic DATA_A_IN_I_ENABLE,
  input logic DATA_A_IN_J_ENABLE,
  input logic DATA_B_IN_I_ENABLE,
  input logic DATA_B_IN_J_ENABLE,
  input ntm_pkg::data_t MODULO_IN,
  input ntm_pkg::data_t DATA_A_IN,
  input ntm_pkg::data_t DATA_B_IN,
  input ntm_pkg::index_t SIZE_A_I_IN,
  input ntm_pkg::index_t SIZE_A_J_IN,
  input ntm_pkg::index_t SIZE_B_J_IN,
  output logic READY,
  output logic DATA_OUT_I_ENABLE,
  output logic DATA_OUT_J_ENABLE,
  output ntm_pkg::data_t DATA_OUT
);

  ////////////////////////////////////////
  // Signals
  ////////////////////////////////////////

  ntm_pkg::product_state_t state;

  // Latched on START
  ntm_pkg::data_t modulo_reg;
  ntm_pkg::index_t size_ai, size_aj, size_bj;

  // Loop indices, C[i][j] += A[i][k]*B[k][j]
  ntm_pkg::index_t i_idx, j_idx, k_idx;
  ntm_pkg::data_t sum;

  // Unit start pulses
  logic mul_start;
  logic add_start;

  logic idle;
  logic clear_buf;
  ntm_pkg::data_t a_elem, b_elem;

  ntm_scalar_if mul_bus ();
  ntm_scalar_if add_bus ();

  assign idle = (state == ntm_pkg::IDLE);
  // Write pointers reset once the product is finished
  assign clear_buf = (state == ntm_pkg::DONE);

  // Multiplier gets A[i][k] and B[k][j]
  assign mul_bus.start = mul_start;
  assign mul_bus.modulo = modulo_reg;
  assign mul_bus.data_a = a_elem;
  assign mul_bus.data_b = b_elem;

  // Adder folds the product into the running sum
  assign add_bus.start = add_start;
  assign add_bus.modulo = modulo_reg;
  assign add_bus.data_a = sum;
  assign add_bus.data_b = mul_bus.data_out;

  ////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state <= ntm_pkg::IDLE;
      {size_ai, size_aj, size_bj} <= '0;
      {i_idx, j_idx, k_idx} <= '0;
      modulo_reg <= '0;
      sum <= '0;
      mul_start <= 1'b0;
      add_start <= 1'b0;
      READY <= 1'b0;
      DATA_OUT_I_ENABLE <= 1'b0;
      DATA_OUT_J_ENABLE <= 1'b0;
      DATA_OUT <= '0;
    end else begin
      // Pulses by default
      mul_start <= 1'b0;
      add_start <= 1'b0;
      READY <= 1'b0;
      DATA_OUT_I_ENABLE <= 1'b0;
      DATA_OUT_J_ENABLE <= 1'b0;
      case (state)
        ntm_pkg::IDLE: begin
          if (START) begin
            size_ai <= SIZE_A_I_IN;
            size_aj <= SIZE_A_J_IN;
            size_bj <= SIZE_B_J_IN;
            modulo_reg <= MODULO_IN;
            {i_idx, j_idx, k_idx} <= '0;
            sum <= '0;
            mul_start <= 1'b1;
            state <= ntm_pkg::MULTIPLY;
          end
        end
        ntm_pkg::MULTIPLY: begin
          // Product held on data_out, hand it to the adder
          if (mul_bus.ready) begin
            add_start <= 1'b1;
            state <= ntm_pkg::ACCUMULATE;
          end
        end
        ntm_pkg::ACCUMULATE: begin
          if (add_bus.ready) begin
            sum <= add_bus.data_out;
            if ((k_idx + 1'b1) == size_aj) begin
              state <= ntm_pkg::EMIT;
            end else begin
              k_idx <= k_idx + 1'b1;
              mul_start <= 1'b1;
              state <= ntm_pkg::MULTIPLY;
            end
          end
        end
        ntm_pkg::EMIT: begin
          DATA_OUT <= sum;
          DATA_OUT_J_ENABLE <= 1'b1;
          // Row strobe on the first element of a row
          DATA_OUT_I_ENABLE <= (j_idx == '0);
          sum <= '0;
          k_idx <= '0;
          if ((j_idx + 1'b1) == size_bj) begin
            j_idx <= '0;
            i_idx <= i_idx + 1'b1;
          end else begin
            j_idx <= j_idx + 1'b1;
          end
          if ((j_idx + 1'b1) == size_bj && (i_idx + 1'b1) == size_ai) begin
            state <= ntm_pkg::DONE;
          end else begin
            mul_start <= 1'b1;
            state <= ntm_pkg::MULTIPLY;
          end
        end
        ntm_pkg::DONE: begin
          READY <= 1'b1;
          state <= ntm_pkg::IDLE;
        end
        default: begin
          state <= ntm_pkg::IDLE;
        end
      endcase
    end
  end

  ////////////////////////////////////////
  // Operand buffers and scalar units
  ////////////////////////////////////////

  // Loads only accepted while idle
  ntm_matrix_buffer matrix_a_inst (
    .CLK(CLK),
    .RST(RST),
    .clear(clear_buf),
    .i_enable(DATA_A_IN_I_ENABLE & idle),
    .j_enable(DATA_A_IN_J_ENABLE & idle),
    .data_in(DATA_A_IN),
    .rd_row(i_idx),
    .rd_col(k_idx),
    .rd_data(a_elem)
  );

  ntm_matrix_buffer matrix_b_inst (
    .CLK(CLK),
    .RST(RST),
    .clear(clear_buf),
    .i_enable(DATA_B_IN_I_ENABLE & idle),
    .j_enable(DATA_B_IN_J_ENABLE & idle),
    .data_in(DATA_B_IN),
    .rd_row(k_idx),
    .rd_col(j_idx),
    .rd_data(b_elem)
  );

  ntm_scalar_multiplier multiplier_inst (
    .CLK(CLK),
    .RST(RST),
    .bus(mul_bus.unit)
  );

  ntm_scalar_adder adder_inst (
    .CLK(CLK),
    .RST(RST),
    .bus(add_bus.unit)
  );

endmodule

/* hw/ntm_pkg.sv */
/*
  Shared types of the matrix product block
  Element, index and control FSM state types
*/

`include "ntm_defines.svh"

package ntm_pkg;

  // One matrix element or modulo value
  typedef logic [`NTM_DATA_SIZE-1:0] data_t;

  // Matrix size, row index or column index
  typedef logic [`NTM_INDEX_SIZE-1:0] index_t;

  // Control FSM of the product top level
  typedef enum logic [2:0] {
    IDLE,
    MULTIPLY,
    ACCUMULATE,
    EMIT,
    DONE
  } product_state_t;

endpackage

/* hw/ntm_scalar_adder.sv */
/*
  Modular adder, one pass
  Result and ready pulse one cycle after start
*/

`timescale 1ns/10ps

`include "ntm_defines.svh"

module ntm_scalar_adder (
  input logic CLK,
  input logic RST,
  ntm_scalar_if.unit bus
);

  ////////////////////////////////////////
  // Combinational sum and reduction
  ////////////////////////////////////////

  // One carry bit above the data width
  logic [`NTM_DATA_SIZE:0] full_sum;
  logic [`NTM_DATA_SIZE:0] reduced_sum;

  always_comb begin
    full_sum = {1'b0, bus.data_a} + {1'b0, bus.data_b};
    // Both operands below modulo, so one subtract is enough
    if (full_sum >= {1'b0, bus.modulo}) begin
      reduced_sum = full_sum - {1'b0, bus.modulo};
    end else begin
      reduced_sum = full_sum;
    end
  end

  ////////////////////////////////////////
  // Registered result and ready
  ////////////////////////////////////////

  // Ready follows start by exactly one cycle
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      bus.ready <= 1'b0;
    end else begin
      bus.ready <= bus.start;
    end
  end

  // Result kept until the next start
  always_ff @(posedge CLK) begin
    if (bus.start) begin
      bus.data_out <= reduced_sum[`NTM_DATA_SIZE-1:0];
    end
  end

endmodule

/* hw/ntm_scalar_if.sv */
/*
  Start/ready operand bus between the product FSM
  and one iterative scalar unit
*/

`timescale 1ns/10ps

interface ntm_scalar_if;

  // Handshake, one-cycle pulses in both directions
  logic start;
  logic ready;

  // Operands, held stable by the master while the unit runs
  ntm_pkg::data_t modulo;
  ntm_pkg::data_t data_a;
  ntm_pkg::data_t data_b;

  // Result, valid with ready and held until the next start
  ntm_pkg::data_t data_out;

  // Control side
  modport master (output start, modulo, data_a, data_b, input ready, data_out);

  // Arithmetic unit side
  modport unit (input start, modulo, data_a, data_b, output ready, data_out);

endinterface

/* hw/ntm_scalar_multiplier.sv */
/*
  Modular multiplier, bit-serial interleaved shift-add
  Scans data_b from the MSB, one bit per cycle
  Ready pulses NTM_DATA_SIZE+1 cycles after start
*/

`timescale 1ns/10ps

`include "ntm_defines.svh"

module ntm_scalar_multiplier (
  input logic CLK,
  input logic RST,
  ntm_scalar_if.unit bus
);

  localparam int CNT_W = $clog2(`NTM_DATA_SIZE);

  // Run control
  logic busy;
  logic [CNT_W-1:0] bit_cnt;

  // Operands latched on start
  ntm_pkg::data_t a_reg;
  ntm_pkg::data_t b_reg;
  ntm_pkg::data_t m_reg;

  // One step of the recurrence r = 2r + b_bit*a (mod m)
  logic [`NTM_DATA_SIZE:0] dbl;
  logic [`NTM_DATA_SIZE:0] dbl_red;
  logic [`NTM_DATA_SIZE:0] add_sum;
  ntm_pkg::data_t step_result;

  ////////////////////////////////////////
  // Step logic
  ////////////////////////////////////////

  always_comb begin
    // Partial result below m, so 2r stays below 2m
    dbl = {bus.data_out, 1'b0};
    dbl_red = (dbl >= {1'b0, m_reg}) ? dbl - {1'b0, m_reg} : dbl;
    add_sum = dbl_red + {1'b0, a_reg};
    if (b_reg[`NTM_DATA_SIZE-1]) begin
      // Add a, then compare-and-subtract once more
      step_result = (add_sum >= {1'b0, m_reg}) ?
                    ntm_pkg::data_t'(add_sum - {1'b0, m_reg}) :
                    ntm_pkg::data_t'(add_sum);
    end else begin
      step_result = dbl_red[`NTM_DATA_SIZE-1:0];
    end
  end

  ////////////////////////////////////////
  // Control
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy <= 1'b0;
      bit_cnt <= '0;
      bus.ready <= 1'b0;
    end else begin
      bus.ready <= 1'b0;
      if (bus.start) begin
        busy <= 1'b1;
        bit_cnt <= '0;
      end else if (busy) begin
        bit_cnt <= bit_cnt + 1'b1;
        // Last bit done, result valid next cycle
        if (bit_cnt == CNT_W'(`NTM_DATA_SIZE - 1)) begin
          busy <= 1'b0;
          bus.ready <= 1'b1;
        end
      end
    end
  end

  // Datapath, data_out doubles as the accumulator
  always_ff @(posedge CLK) begin
    if (bus.start) begin
      a_reg <= bus.data_a;
      b_reg <= bus.data_b;
      m_reg <= bus.modulo;
      bus.data_out <= '0;
    end else if (busy) begin
      bus.data_out <= step_result;
      b_reg <= {b_reg[`NTM_DATA_SIZE-2:0], 1'b0};
    end
  end

endmodule

/* testbench/ntm_matrix_product_checks.svh */
/*
  Compare tasks and error counters for the matrix product testbench
  One task per kind of result: element data, strobe bits, totals
*/

`ifndef NTM_MATRIX_PRODUCT_CHECKS_SVH
`define NTM_MATRIX_PRODUCT_CHECKS_SVH

// Failure counts, one per kind of check
int data_errors = 0;
int flag_errors = 0;
int count_errors = 0;
int other_errors = 0;

// Element of C or output data word
task automatic check_data(input string name, input ntm_pkg::data_t exp,
                          input ntm_pkg::data_t act);
  if (act !== exp) begin
    data_errors++;
    $display("Error %s: expected 0x%h, got 0x%h at %0t", name, exp, act, $time);
  end
endtask

// Strobe and framing bits
task automatic check_flag(input string name, input logic exp, input logic act);
  if (act !== exp) begin
    flag_errors++;
    $display("Error %s: expected 0x%h, got 0x%h at %0t", name, exp, act, $time);
  end
endtask

// Element, row and pulse totals of one product
task automatic check_count(input string name, input int exp, input int act);
  if (act != exp) begin
    count_errors++;
    $display("Error %s: expected 0x%0h, got 0x%0h", name, exp, act);
  end
endtask

`endif

/* testbench/ntm_matrix_product_tb.sv */
/*
  Testbench for the modular matrix product
  Clock, reset, operand loading, reference model, output monitor, timeout
*/

`timescale 1ns/10ps

`include "ntm_defines.svh"

module ntm_matrix_product_tb;

  logic CLK = 1'b0;
  logic RST, START, READY, DATA_OUT_I_ENABLE, DATA_OUT_J_ENABLE;
  logic DATA_A_IN_I_ENABLE, DATA_A_IN_J_ENABLE, DATA_B_IN_I_ENABLE, DATA_B_IN_J_ENABLE;
  ntm_pkg::data_t MODULO_IN, DATA_A_IN, DATA_B_IN, DATA_OUT;
  ntm_pkg::index_t SIZE_A_I_IN, SIZE_A_J_IN, SIZE_B_J_IN;

  `include "ntm_matrix_product_checks.svh"

  // Current operands and sizes, shared by stimulus, reference and monitor
  ntm_pkg::data_t a_mat [`NTM_MAX_DIM][`NTM_MAX_DIM];
  ntm_pkg::data_t b_mat [`NTM_MAX_DIM][`NTM_MAX_DIM];
  int cur_ai = 1, cur_aj = 1, cur_bj = 1;
  longint unsigned cur_mod = 2;
  integer seed;
  ntm_pkg::data_t exp_q [$];
  int elem_cnt = 0, row_cnt = 0, ready_cnt = 0;
  bit ready_due = 1'b0, started = 1'b0;
  // Grows with every product, covers reset and idle check at first
  int cycle_limit = 100;
  int cycle_cnt = 0;

  ntm_matrix_product ntm_matrix_product_inst (.*);

  always #5 CLK = ~CLK;

  // One element of C, each step reduced mod m
  function automatic ntm_pkg::data_t ref_element(input int i, input int j);
    longint unsigned acc;
    acc = 0;
    for (int k = 0; k < cur_aj; k++) begin
      acc = (acc + longint'(a_mat[i][k]) * longint'(b_mat[k][j])) % cur_mod;
    end
    return ntm_pkg::data_t'(acc);
  endfunction

  task automatic print_summary();
    $display("Errors: data %0d, flag %0d, count %0d, other %0d",
             data_errors, flag_errors, count_errors, other_errors);
  endtask

  ////////////////////////////////////////
  // Output monitor
  ////////////////////////////////////////

  // Sampled mid-cycle, away from the driving edge
  always @(negedge CLK) begin
    if (!RST) begin
      // READY only right after the last element strobe
      check_flag("READY", ready_due, READY);
      if (READY) ready_cnt++;
      ready_due = 1'b0;
      if (!started) check_data("DATA_OUT", '0, DATA_OUT);
      if (DATA_OUT_J_ENABLE) begin
        if (exp_q.size() == 0) begin
          other_errors++;
          $display("Element strobe seen with no element of C pending at %0t", $time);
        end else begin
          check_data("DATA_OUT", exp_q.pop_front(), DATA_OUT);
          // Row strobe on every B_J-th element, first one included
          check_flag("DATA_OUT_I_ENABLE", (elem_cnt % cur_bj) == 0, DATA_OUT_I_ENABLE);
          if (DATA_OUT_I_ENABLE) row_cnt++;
          elem_cnt++;
          ready_due = (exp_q.size() == 0);
        end
      end else begin
        check_flag("DATA_OUT_I_ENABLE", 1'b0, DATA_OUT_I_ENABLE);
      end
    end
  end

  ////////////////////////////////////////
  // Stimulus tasks
  ////////////////////////////////////////

  // Row-major load, I strobe with the first element of each row
  task automatic load_operands();
    for (int r = 0; r < cur_ai; r++) begin
      for (int c = 0; c < cur_aj; c++) begin
        @(posedge CLK);
        DATA_A_IN_I_ENABLE <= (c == 0);
        DATA_A_IN_J_ENABLE <= 1'b1;
        DATA_A_IN <= a_mat[r][c];
      end
    end
    @(posedge CLK);
    DATA_A_IN_I_ENABLE <= 1'b0;
    DATA_A_IN_J_ENABLE <= 1'b0;
    for (int r = 0; r < cur_aj; r++) begin
      for (int c = 0; c < cur_bj; c++) begin
        @(posedge CLK);
        DATA_B_IN_I_ENABLE <= (c == 0);
        DATA_B_IN_J_ENABLE <= 1'b1;
        DATA_B_IN <= b_mat[r][c];
      end
    end
    @(posedge CLK);
    DATA_B_IN_I_ENABLE <= 1'b0;
    DATA_B_IN_J_ENABLE <= 1'b0;
  endtask

  // Random dimensions, modulo and operands below the modulo
  task automatic fill_random();
    cur_ai = 1 + ($unsigned($random(seed)) % `NTM_MAX_DIM);
    cur_aj = 1 + ($unsigned($random(seed)) % `NTM_MAX_DIM);
    cur_bj = 1 + ($unsigned($random(seed)) % `NTM_MAX_DIM);
    cur_mod = 2 + ($unsigned($random(seed)) % ((1 << `NTM_DATA_SIZE) - 2));
    for (int r = 0; r < `NTM_MAX_DIM; r++) begin
      for (int c = 0; c < `NTM_MAX_DIM; c++) begin
        a_mat[r][c] = ntm_pkg::data_t'($unsigned($random(seed)) % cur_mod);
        b_mat[r][c] = ntm_pkg::data_t'($unsigned($random(seed)) % cur_mod);
      end
    end
  endtask

  // Load, start, optionally disturb, wait for READY, check totals
  task automatic run_product(input bit interfere);
    cycle_limit += cur_ai * cur_bj * cur_aj * (`NTM_DATA_SIZE + 6) + 40 +
                   cur_ai * cur_aj + cur_aj * cur_bj;
    load_operands();
    for (int i = 0; i < cur_ai; i++) begin
      for (int j = 0; j < cur_bj; j++) exp_q.push_back(ref_element(i, j));
    end
    elem_cnt = 0;
    row_cnt = 0;
    ready_cnt = 0;
    @(posedge CLK);
    START <= 1'b1;
    MODULO_IN <= ntm_pkg::data_t'(cur_mod);
    SIZE_A_I_IN <= ntm_pkg::index_t'(cur_ai);
    SIZE_A_J_IN <= ntm_pkg::index_t'(cur_aj);
    SIZE_B_J_IN <= ntm_pkg::index_t'(cur_bj);
    started = 1'b1;
    @(posedge CLK);
    START <= 1'b0;
    if (interfere) begin
      // Stray START and load strobes with junk while busy
      repeat (2) @(posedge CLK);
      repeat (6) begin
        @(posedge CLK);
        {START, DATA_A_IN_I_ENABLE, DATA_A_IN_J_ENABLE} <= 3'b111;
        {DATA_B_IN_I_ENABLE, DATA_B_IN_J_ENABLE} <= 2'b11;
        DATA_A_IN <= ntm_pkg::data_t'($random(seed));
        DATA_B_IN <= ntm_pkg::data_t'($random(seed));
        MODULO_IN <= ntm_pkg::data_t'($random(seed));
      end
      @(posedge CLK);
      {START, DATA_A_IN_I_ENABLE, DATA_A_IN_J_ENABLE} <= 3'b000;
      {DATA_B_IN_I_ENABLE, DATA_B_IN_J_ENABLE} <= 2'b00;
    end
    while (ready_cnt == 0) @(posedge CLK);
    @(posedge CLK);
    check_count("DATA_OUT_J_ENABLE strobes", cur_ai * cur_bj, elem_cnt);
    check_count("DATA_OUT_I_ENABLE strobes", cur_ai, row_cnt);
    check_count("READY pulses", 1, ready_cnt);
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    seed = 32'h6124;
    RST <= 1'b1;
    {START, DATA_A_IN_I_ENABLE, DATA_A_IN_J_ENABLE} <= 3'b000;
    {DATA_B_IN_I_ENABLE, DATA_B_IN_J_ENABLE} <= 2'b00;
    {MODULO_IN, DATA_A_IN, DATA_B_IN} <= '0;
    {SIZE_A_I_IN, SIZE_A_J_IN, SIZE_B_J_IN} <= '0;
    repeat (16) @(posedge CLK);
    RST <= 1'b0;
    // Outputs must stay quiet before the first START
    repeat (10) @(posedge CLK);
    // Directed 2x2 mod 7, C[0][0] = 42 wraps to 0
    cur_ai = 2;
    cur_aj = 2;
    cur_bj = 2;
    cur_mod = 7;
    a_mat[0][0] = 3;
    a_mat[0][1] = 5;
    a_mat[1][0] = 6;
    a_mat[1][1] = 2;
    b_mat[0][0] = 4;
    b_mat[0][1] = 1;
    b_mat[1][0] = 6;
    b_mat[1][1] = 5;
    run_product(1'b0);
    repeat (20) begin
      fill_random();
      run_product(1'b0);
    end
    // Disturbed run, then a clean one on fresh matrices
    cur_ai = 2;
    cur_aj = 3;
    cur_bj = 2;
    run_product(1'b1);
    fill_random();
    run_product(1'b0);
    // Largest modulo, operands one below it
    cur_ai = `NTM_MAX_DIM;
    cur_aj = `NTM_MAX_DIM;
    cur_bj = `NTM_MAX_DIM;
    cur_mod = (1 << `NTM_DATA_SIZE) - 1;
    for (int r = 0; r < `NTM_MAX_DIM; r++) begin
      for (int c = 0; c < `NTM_MAX_DIM; c++) begin
        a_mat[r][c] = ntm_pkg::data_t'(cur_mod - 1);
        b_mat[r][c] = ntm_pkg::data_t'(cur_mod - 1);
      end
    end
    run_product(1'b0);
    repeat (5) @(posedge CLK);
    print_summary();
    if (data_errors + flag_errors + count_errors + other_errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  // Watchdog, limit raised by each product before it runs
  initial begin
    while (cycle_cnt < cycle_limit) begin
      @(posedge CLK);
      cycle_cnt++;
    end
    other_errors++;
    $display("Timeout: run did not finish within %0d cycles", cycle_limit);
    print_summary();
    $display("=== FAIL ===");
    $finish;
  end

endmodule
